/* rtl/mipsPkg.sv */
////////////////////////////////////////////////////////////////////////////
// MIPS subset core shared definitions
// Widths, opcodes, ALU codes and the records passed between stages
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package mipsPkg;

    // Basic vector types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [1:0]  aluOp_t;
    typedef logic [3:0]  aluCtrl_t;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    // Main opcodes
    localparam opcode_t opR    = 6'h00;
    localparam opcode_t opAddi = 6'h08;
    localparam opcode_t opLw   = 6'h23;
    localparam opcode_t opSw   = 6'h2B;
    localparam opcode_t opBeq  = 6'h04;
    localparam opcode_t opBne  = 6'h05;

    // R-type funct field
    localparam funct_t functAdd = 6'h20;
    localparam funct_t functSub = 6'h22;
    localparam funct_t functAnd = 6'h24;
    localparam funct_t functOr  = 6'h25;
    localparam funct_t functSlt = 6'h2A;

    // ALU class from the main decoder
    localparam aluOp_t aluOpAdd   = 2'b00;
    localparam aluOp_t aluOpSub   = 2'b01;
    localparam aluOp_t aluOpFunct = 2'b10;
    localparam aluOp_t aluOpOr    = 2'b11;

    // ALU operations, classic control codes
    localparam aluCtrl_t aluAnd = 4'b0000;
    localparam aluCtrl_t aluOr  = 4'b0001;
    localparam aluCtrl_t aluAdd = 4'b0010;
    localparam aluCtrl_t aluSub = 4'b0110;
    localparam aluCtrl_t aluSlt = 4'b0111;

    // Storage sizes
    localparam int    numRegs      = 32;
    localparam int    dataMemWords = 64;
    localparam int    memIndexBits = $clog2(dataMemWords);
    localparam word_t resetPc      = 32'h0000_0000;

    ////////////////////////////////////////////////////////////////////////////
    // Stage records
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic   regWrite;
        logic   memRead;
        logic   memWrite;
        logic   memToReg;
        logic   branch;
        logic   branchNe;
        logic   aluSrc;
        aluOp_t aluOp;
    } ctrl_t;

    // Decode to execute
    typedef struct packed {
        ctrl_t    ctrl;
        word_t    pcPlus4;
        word_t    rsData;
        word_t    rtData;
        word_t    imm;
        regAddr_t writeReg;
        funct_t   funct;
    } idEx_t;

    // Execute to result
    typedef struct packed {
        logic     regWrite;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        word_t    aluResult;
        word_t    storeData;
        regAddr_t writeReg;
    } exRes_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

    // Write-back, also the forwarding source
    typedef struct packed {
        logic     valid;
        regAddr_t writeReg;
        word_t    data;
    } wb_t;

endpackage

`default_nettype wire

/* rtl/mipsRegFile.sv */
////////////////////////////////////////////////////////////////////////////
// Register file
// Two combinational read ports, one write port, register zero tied low
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mipsRegFile (
    input  logic              clock,
    input  logic              arstN,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    output mipsPkg::word_t    rsData,
    output mipsPkg::word_t    rtData,
    input  mipsPkg::wb_t      wb
);

    mipsPkg::word_t regs [mipsPkg::numRegs];

    // Write at the end of the execute/result cycle
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < mipsPkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.writeReg != '0)) begin
            regs[wb.writeReg] <= wb.data;
        end
    end

    // Reads, $zero forced
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

    // Result stage must never flag a write to $zero
    assert property (@(posedge clock) disable iff (!arstN)
        wb.valid |-> (wb.writeReg != '0))
        else $error("write-back valid with register zero");

endmodule

`default_nettype wire

/* rtl/mipsDecode.sv */
////////////////////////////////////////////////////////////////////////////
// Decode stage
// PC, fetch/decode register, control decode, forwarding, ID/EX register
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mipsDecode (
    input  logic               clock,
    input  logic               arstN,
    output mipsPkg::word_t     fetchAddr,
    input  mipsPkg::word_t     fetchInstr,
    input  mipsPkg::redirect_t redirect,
    input  mipsPkg::wb_t       wb,
    output mipsPkg::idEx_t     idEx
);

    mipsPkg::word_t    pc;
    mipsPkg::word_t    pcPlus4;
    mipsPkg::word_t    ifInstr;
    mipsPkg::word_t    ifPcPlus4;
    mipsPkg::opcode_t  opcode;
    mipsPkg::regAddr_t rs;
    mipsPkg::regAddr_t rt;
    mipsPkg::regAddr_t rd;
    mipsPkg::funct_t   funct;
    logic [15:0]       immField;
    logic              regDst;
    mipsPkg::ctrl_t    ctrl;
    mipsPkg::word_t    rfRsData;
    mipsPkg::word_t    rfRtData;
    mipsPkg::word_t    rsData;
    mipsPkg::word_t    rtData;
    mipsPkg::idEx_t    idExNext;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch side
    ////////////////////////////////////////////////////////////////////////////

    // Fetch port is the PC itself
    assign fetchAddr = pc;
    assign pcPlus4   = pc + 32'd4;

    // Taken branch in execute steers the next fetch
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc <= mipsPkg::resetPc;
        end else if (redirect.taken) begin
            pc <= redirect.target;
        end else begin
            pc <= pcPlus4;
        end
    end

    // IF/ID register, zero word is a nop
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            ifInstr   <= '0;
            ifPcPlus4 <= '0;
        end else begin
            ifInstr   <= fetchInstr;
            ifPcPlus4 <= pcPlus4;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    // Instruction fields
    assign opcode   = ifInstr[31:26];
    assign rs       = ifInstr[25:21];
    assign rt       = ifInstr[20:16];
    assign rd       = ifInstr[15:11];
    assign funct    = ifInstr[5:0];
    assign immField = ifInstr[15:0];

    // R-type writes rd, everything else rt
    assign regDst = (opcode == mipsPkg::opR);

    // Main control, unknown opcodes fall through as nop
    always_comb begin
        ctrl = '0;
        case (opcode)
            mipsPkg::opR: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::aluOpFunct;
            end
            mipsPkg::opAddi: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluOpAdd;
            end
            mipsPkg::opLw: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluOpAdd;
            end
            mipsPkg::opSw: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = mipsPkg::aluOpAdd;
            end
            mipsPkg::opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = mipsPkg::aluOpSub;
            end
            mipsPkg::opBne: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = mipsPkg::aluOpSub;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    mipsRegFile regFile (
        .clock  (clock),
        .arstN  (arstN),
        .rsAddr (rs),
        .rtAddr (rt),
        .rsData (rfRsData),
        .rtData (rfRtData),
        .wb     (wb)
    );

    // Forward from the instruction now in execute
    // (valid already excludes $zero)
    assign rsData = (wb.valid && (wb.writeReg == rs)) ? wb.data : rfRsData;
    assign rtData = (wb.valid && (wb.writeReg == rt)) ? wb.data : rfRtData;

    always_comb begin
        idExNext.ctrl     = ctrl;
        idExNext.pcPlus4  = ifPcPlus4;
        idExNext.rsData   = rsData;
        idExNext.rtData   = rtData;
        idExNext.imm      = {{16{immField[15]}}, immField};
        idExNext.writeReg = regDst ? rd : rt;
        idExNext.funct    = funct;
    end

    // ID/EX register
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

    // A load and a store in one instruction would corrupt the result stage
    assert property (@(posedge clock) disable iff (!arstN)
        !(idEx.ctrl.memRead && idEx.ctrl.memWrite))
        else $error("memRead and memWrite both set");

endmodule

`default_nettype wire

/* rtl/mipsExecute.sv */
////////////////////////////////////////////////////////////////////////////
// Execute stage
// ALU control, ALU, operand select and branch resolution
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mipsExecute (
    input  mipsPkg::idEx_t     idEx,
    output mipsPkg::exRes_t    exRes,
    output mipsPkg::redirect_t redirect
);

    mipsPkg::aluCtrl_t aluCtrl;
    mipsPkg::word_t    opB;
    mipsPkg::word_t    aluResult;
    logic              zero;

    // ALU control from class and funct
    always_comb begin
        case (idEx.ctrl.aluOp)
            mipsPkg::aluOpAdd: aluCtrl = mipsPkg::aluAdd;
            mipsPkg::aluOpSub: aluCtrl = mipsPkg::aluSub;
            mipsPkg::aluOpOr:  aluCtrl = mipsPkg::aluOr;
            default: begin
                case (idEx.funct)
                    mipsPkg::functAdd: aluCtrl = mipsPkg::aluAdd;
                    mipsPkg::functSub: aluCtrl = mipsPkg::aluSub;
                    mipsPkg::functAnd: aluCtrl = mipsPkg::aluAnd;
                    mipsPkg::functOr:  aluCtrl = mipsPkg::aluOr;
                    mipsPkg::functSlt: aluCtrl = mipsPkg::aluSlt;
                    // Shift nop and friends
                    default:           aluCtrl = mipsPkg::aluAdd;
                endcase
            end
        endcase
    end

    // Immediate or register for the second operand
    assign opB = idEx.ctrl.aluSrc ? idEx.imm : idEx.rtData;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        aluResult = '0;
        case (aluCtrl)
            mipsPkg::aluAnd: aluResult = idEx.rsData & opB;
            mipsPkg::aluOr:  aluResult = idEx.rsData | opB;
            mipsPkg::aluAdd: aluResult = idEx.rsData + opB;
            mipsPkg::aluSub: aluResult = idEx.rsData - opB;
            // Signed compare, result in bit 0
            mipsPkg::aluSlt: aluResult[0] = $signed(idEx.rsData) < $signed(opB);
            default:         aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // Record for the result stage
    always_comb begin
        exRes.regWrite  = idEx.ctrl.regWrite;
        exRes.memRead   = idEx.ctrl.memRead;
        exRes.memWrite  = idEx.ctrl.memWrite;
        exRes.memToReg  = idEx.ctrl.memToReg;
        exRes.aluResult = aluResult;
        exRes.storeData = idEx.rtData;
        exRes.writeReg  = idEx.writeReg;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Branch
    ////////////////////////////////////////////////////////////////////////////

    // beq on equal, bne on not equal
    assign redirect.taken  = idEx.ctrl.branch && (idEx.ctrl.branchNe ? !zero : zero);
    // Word offset relative to the delay slot
    assign redirect.target = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};

endmodule

`default_nettype wire

/* rtl/mipsResult.sv */
////////////////////////////////////////////////////////////////////////////
// Result stage
// Data memory and write-back record
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mipsResult (
    input  logic             clock,
    input  logic             arstN,
    input  mipsPkg::exRes_t  exRes,
    output mipsPkg::wb_t     wb
);

    mipsPkg::word_t                dataMem [mipsPkg::dataMemWords];
    logic [mipsPkg::memIndexBits-1:0] memIndex;
    mipsPkg::word_t                loadData;

    // Word address wraps at the memory size
    assign memIndex = exRes.aluResult[mipsPkg::memIndexBits+1:2];

    // Store at the edge closing the execute cycle
    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < mipsPkg::dataMemWords; i++) begin
                dataMem[i] <= '0;
            end
        end else if (exRes.memWrite) begin
            dataMem[memIndex] <= exRes.storeData;
        end
    end

    // Combinational read, so a load can be forwarded right away
    assign loadData = exRes.memRead ? dataMem[memIndex] : '0;

    // Write-back, no write to $zero
    assign wb.valid    = exRes.regWrite && (exRes.writeReg != '0);
    assign wb.writeReg = exRes.writeReg;
    assign wb.data     = exRes.memToReg ? loadData : exRes.aluResult;

    // Word access only
    assert property (@(posedge clock) disable iff (!arstN)
        (exRes.memRead || exRes.memWrite) |-> (exRes.aluResult[1:0] == 2'b00))
        else $error("unaligned data memory access");

endmodule

`default_nettype wire

/* rtl/mipsCore.sv */
////////////////////////////////////////////////////////////////////////////
// MIPS subset core top level
// Three-stage pipeline, fetch port to external instruction memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mipsCore (
    input  logic           clock,
    input  logic           arstN,
    output mipsPkg::word_t fetchAddr,
    input  mipsPkg::word_t fetchInstr,
    output mipsPkg::wb_t   wb
);

    // Stage links
    mipsPkg::idEx_t     idEx;
    mipsPkg::exRes_t    exRes;
    mipsPkg::redirect_t redirect;

    // PC, IF/ID, register file, ID/EX
    mipsDecode decode (
        .clock      (clock),
        .arstN      (arstN),
        .fetchAddr  (fetchAddr),
        .fetchInstr (fetchInstr),
        .redirect   (redirect),
        .wb         (wb),
        .idEx       (idEx)
    );

    // ALU and branch
    mipsExecute execute (
        .idEx     (idEx),
        .exRes    (exRes),
        .redirect (redirect)
    );

    // Data memory, write-back out to the port and back to decode
    mipsResult result (
        .clock (clock),
        .arstN (arstN),
        .exRes (exRes),
        .wb    (wb)
    );

endmodule

`default_nettype wire

/* testbench/mipsProgram.svh */
////////////////////////////////////////////////////////////////////////////
// Test program for the MIPS subset core
// One line per instruction, with the write-back it must produce
////////////////////////////////////////////////////////////////////////////

`ifndef MIPS_PROGRAM_SVH
`define MIPS_PROGRAM_SVH

    // Register 0 in the second column means no write-back expected
    task automatic loadProgram();
        // Constants
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd1, 16'd5), 5'd1, 32'd5);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd2, 16'd12), 5'd2, 32'd12);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd3, 16'hFFFD), 5'd3, 32'hFFFF_FFFD);
        // R-type ALU ops, slt true then false
        addStep(rTypeWord(5'd1, 5'd2, 5'd4, mipsPkg::functAdd), 5'd4, 32'd17);
        addStep(rTypeWord(5'd1, 5'd2, 5'd5, mipsPkg::functSub), 5'd5, 32'hFFFF_FFF9);
        addStep(rTypeWord(5'd2, 5'd1, 5'd6, mipsPkg::functAnd), 5'd6, 32'd4);
        addStep(rTypeWord(5'd2, 5'd1, 5'd7, mipsPkg::functOr), 5'd7, 32'd13);
        addStep(rTypeWord(5'd3, 5'd1, 5'd8, mipsPkg::functSlt), 5'd8, 32'd1);
        addStep(rTypeWord(5'd1, 5'd3, 5'd9, mipsPkg::functSlt), 5'd9, 32'd0);
        // Back-to-back dependency chain
        addStep(iTypeWord(mipsPkg::opAddi, 5'd1, 5'd10, 16'd1), 5'd10, 32'd6);
        addStep(rTypeWord(5'd10, 5'd10, 5'd11, mipsPkg::functAdd), 5'd11, 32'd12);
        addStep(rTypeWord(5'd11, 5'd1, 5'd12, mipsPkg::functSub), 5'd12, 32'd7);
        // Store to 72, reload through another base, then use at once
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd13, 16'd64), 5'd13, 32'd64);
        addStep(iTypeWord(mipsPkg::opSw, 5'd13, 5'd11, 16'd8), 5'd0, 32'd0);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd14, 16'd80), 5'd14, 32'd80);
        addStep(iTypeWord(mipsPkg::opLw, 5'd14, 5'd15, 16'hFFF8), 5'd15, 32'd12);
        addStep(rTypeWord(5'd15, 5'd1, 5'd16, mipsPkg::functAdd), 5'd16, 32'd17);
        // Never stored
        addStep(iTypeWord(mipsPkg::opLw, 5'd13, 5'd17, 16'd4), 5'd17, 32'd0);
        // beq taken at 72, target 88
        addStep(iTypeWord(mipsPkg::opBeq, 5'd1, 5'd1, 16'd3), 5'd0, 32'd0);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd18, 16'd1), 5'd18, 32'd1);
        expectFetch(32'd88);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd19, 16'd2), 5'd19, 32'd2);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd20, 16'd99), 5'd0, 32'd0);
        // bne not taken at 88
        addStep(iTypeWord(mipsPkg::opBne, 5'd1, 5'd1, 16'd5), 5'd0, 32'd0);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd21, 16'd3), 5'd21, 32'd3);
        expectFetch(32'd100);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd22, 16'd4), 5'd22, 32'd4);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd23, 16'd5), 5'd23, 32'd5);
        // beq not taken at 104
        addStep(iTypeWord(mipsPkg::opBeq, 5'd1, 5'd2, 16'd10), 5'd0, 32'd0);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd24, 16'd6), 5'd24, 32'd6);
        expectFetch(32'd116);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd25, 16'd7), 5'd25, 32'd7);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd26, 16'd8), 5'd26, 32'd8);
        // bne taken at 120, target 136
        addStep(iTypeWord(mipsPkg::opBne, 5'd1, 5'd2, 16'd3), 5'd0, 32'd0);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd27, 16'd9), 5'd27, 32'd9);
        expectFetch(32'd136);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd28, 16'd10), 5'd28, 32'd10);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd30, 16'd77), 5'd0, 32'd0);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd29, 16'd11), 5'd29, 32'd11);
        // Writes to $zero vanish, $zero still reads zero
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd0, 16'd55), 5'd0, 32'd0);
        addStep(rTypeWord(5'd1, 5'd2, 5'd0, mipsPkg::functAdd), 5'd0, 32'd0);
        addStep(iTypeWord(mipsPkg::opAddi, 5'd0, 5'd31, 16'd7), 5'd31, 32'd7);
    endtask

`endif

/* testbench/mipsCoreTb.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the MIPS subset core
// Answers fetches from a program table, checks the write-back sequence
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`default_nettype none

module mipsCoreTb;

    // One expected write-back, optionally with the fetch address beside it
    typedef struct packed {
        mipsPkg::regAddr_t writeReg;
        mipsPkg::word_t    data;
        logic              checkFetch;
        mipsPkg::word_t    fetchAddr;
    } wbExpect_t;

    logic           clock;
    logic           arstN;
    mipsPkg::word_t fetchAddr;
    mipsPkg::word_t fetchInstr;
    mipsPkg::wb_t   wb;

    mipsPkg::word_t programWords[$];
    wbExpect_t      expected[$];
    int             errors;
    int             tests;
    int             waitCycles;
    logic           aborted;

    mipsCore DUT (
        .clock      (clock),
        .arstN      (arstN),
        .fetchAddr  (fetchAddr),
        .fetchInstr (fetchInstr),
        .wb         (wb)
    );

    // 20 ns clock
    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction encoding and table building
    ////////////////////////////////////////////////////////////////////////////

    function automatic mipsPkg::word_t rTypeWord(input mipsPkg::regAddr_t rs,
                                                 input mipsPkg::regAddr_t rt,
                                                 input mipsPkg::regAddr_t rd,
                                                 input mipsPkg::funct_t   funct);
        return {mipsPkg::opR, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic mipsPkg::word_t iTypeWord(input mipsPkg::opcode_t  op,
                                                 input mipsPkg::regAddr_t rs,
                                                 input mipsPkg::regAddr_t rt,
                                                 input logic [15:0]       imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addStep(input mipsPkg::word_t instr, input mipsPkg::regAddr_t writeReg,
                           input mipsPkg::word_t data);
        wbExpect_t entry;
        programWords.push_back(instr);
        if (writeReg != '0) begin
            entry.writeReg   = writeReg;
            entry.data       = data;
            entry.checkFetch = 1'b0;
            entry.fetchAddr  = '0;
            expected.push_back(entry);
        end
    endtask

    // Attach a fetch address check to the latest write-back
    task automatic expectFetch(input mipsPkg::word_t addr);
        wbExpect_t entry;
        entry            = expected.pop_back();
        entry.checkFetch = 1'b1;
        entry.fetchAddr  = addr;
        expected.push_back(entry);
    endtask

    // Nop past the end of the table
    function automatic mipsPkg::word_t instrAt(input mipsPkg::word_t addr);
        int index;
        index = int'(addr[31:2]);
        if (index < programWords.size()) begin
            return programWords[index];
        end
        return '0;
    endfunction

    // Instruction memory, updated just after each rising edge
    initial begin
        fetchInstr = '0;
        forever begin
            @(posedge clock);
            #2;
            fetchInstr = instrAt(fetchAddr);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkWriteBack(input int index);
        wbExpect_t entry;
        int        errorsBefore;
        entry        = expected[index];
        errorsBefore = errors;
        if (wb.writeReg !== entry.writeReg) begin
            $display("mismatch at %0t: wb.writeReg expected %0d got %0d",
                     $time, entry.writeReg, wb.writeReg);
            errors++;
        end
        if (wb.data !== entry.data) begin
            $display("mismatch at %0t: wb.data expected %h got %h", $time, entry.data, wb.data);
            errors++;
        end
        // Cycle after the branch resolved
        if (entry.checkFetch && (fetchAddr !== entry.fetchAddr)) begin
            $display("mismatch at %0t: fetchAddr expected %h got %h",
                     $time, entry.fetchAddr, fetchAddr);
            errors++;
        end
        $display("test %0d, write-back to r%0d: %s", tests, entry.writeReg,
                 (errors == errorsBefore) ? "pass" : "fail");
    endtask

    initial begin
        int errorsBefore;
        errors  = 0;
        tests   = 0;
        aborted = 1'b0;
        arstN   = 1'b0;
        loadProgram();

        // Reset held for 8 edges, outputs quiet
        errorsBefore = errors;
        for (int c = 0; c < 8; c++) begin
            @(posedge clock);
            #1;
            if (fetchAddr !== mipsPkg::resetPc) begin
                $display("mismatch at %0t: fetchAddr expected %h got %h",
                         $time, mipsPkg::resetPc, fetchAddr);
                errors++;
            end
            if (wb.valid !== 1'b0) begin
                $display("mismatch at %0t: wb.valid expected 0 got %b", $time, wb.valid);
                errors++;
            end
        end
        #1;
        arstN = 1'b1;
        tests++;
        $display("test %0d, reset state: %s", tests, (errors == errorsBefore) ? "pass" : "fail");

        // Walk the expected write-backs in order
        for (int i = 0; (i < expected.size()) && !aborted; i++) begin
            tests++;
            @(negedge clock);
            waitCycles = 1;
            while ((wb.valid !== 1'b1) && (waitCycles < 40)) begin
                @(negedge clock);
                waitCycles++;
            end
            if (wb.valid !== 1'b1) begin
                $display("test %0d: no write-back to r%0d within 40 cycles, stopping",
                         tests, expected[i].writeReg);
                errors++;
                aborted = 1'b1;
            end else begin
                checkWriteBack(i);
            end
        end

        // Nothing more may write back, skipped paths included
        if (!aborted) begin
            tests++;
            errorsBefore = errors;
            for (int c = 0; c < 12; c++) begin
                @(negedge clock);
                if (wb.valid === 1'b1) begin
                    $display("unexpected write-back to r%0d at %0t after the last expected one",
                             wb.writeReg, $time);
                    errors++;
                end
            end
            $display("test %0d, no extra write-backs: %s", tests,
                     (errors == errorsBefore) ? "pass" : "fail");
        end

        $display("%0d tests run, %0d failed checks", tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    `include "mipsProgram.svh"

endmodule

`default_nettype wire

/* mipsCore.f */
+incdir+testbench
rtl/mipsPkg.sv
rtl/mipsRegFile.sv
rtl/mipsDecode.sv
rtl/mipsExecute.sv
rtl/mipsResult.sv
rtl/mipsCore.sv
testbench/mipsCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the mipsCore testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -f mipsCore.f --top-module mipsCoreTb \
    --Mdir obj_dir -o mipsCoreSim > build.log 2>&1 \
    || { cat build.log; echo "FAIL: build"; exit 1; }
./obj_dir/mipsCoreSim > sim.log 2>&1
cat sim.log
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
